// ==== hw/rv32i_pkg.sv ====
`default_nettype none

package rv32i_pkg;

  typedef logic [31:0] rv32i_word;

  typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_jal   = 7'b1101111,
    op_jalr  = 7'b1100111,
    op_br    = 7'b1100011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
  } opcode_t;

  // Slots 010 and 011 are free in funct3 (slt/sltu go to cmp).
  typedef enum logic [2:0] {
    alu_add, alu_sll, alu_sra, alu_sub, alu_xor, alu_srl, alu_or, alu_and
  } alu_ops_t;

  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_funct3_t;

  typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
  } load_funct3_t;
  typedef enum logic [2:0] {sb = 3'b000, sh = 3'b001, sw = 3'b010} store_funct3_t;

  typedef enum logic [1:0] {pc_plus4, alu_out, alu_mod2} pcmux_sel_t;

  typedef enum logic [1:0] {a1_rs1, a1_pc, a1_zero} alumux1_sel_t;
  typedef enum logic {a2_rs2, a2_imm} alumux2_sel_t;
  typedef enum logic [2:0] {rf_alu, rf_cmp, rf_u_imm, rf_pc4, rf_load} regfilemux_sel_t;

  typedef enum logic [1:0] {fwd_none = 2'b00, fwd_mem_wb = 2'b01, fwd_ex_mem = 2'b10} fwd_sel_t;

  typedef struct packed {
    opcode_t         opcode;
    alu_ops_t        aluop;
    branch_funct3_t  cmpop;
    logic [2:0]      funct3;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    rv32i_word       u_imm;
    rv32i_word       imm;
    alumux1_sel_t    alumux1_sel;
    alumux2_sel_t    alumux2_sel;
    pcmux_sel_t      pcmux_sel;
    regfilemux_sel_t load_regfilemux_sel;
    logic            mem_read;
    logic            mem_write;
    logic            load_regfile;
    logic            valid;
  } rv32i_control_word;

endpackage

`default_nettype wire

// ==== hw/ex_mem_if.sv ====
`default_nettype none

interface ex_mem_if import rv32i_pkg::*; ();

  rv32i_control_word ctrl;
  rv32i_word         instruction;
  rv32i_word         pc;
  rv32i_word         alu_out;
  logic              br_en;
  rv32i_word         rs2_out;         // Store data, not yet shifted.
  logic [3:0]        mem_byte_enable;
  logic [1:0]        addr_offset;

  modport producer (
    output ctrl, instruction, pc, alu_out, br_en, rs2_out, mem_byte_enable, addr_offset
  );

  modport consumer (
    input ctrl, instruction, pc, alu_out, br_en, rs2_out, mem_byte_enable, addr_offset
  );

endinterface

`default_nettype wire

// ==== hw/alu.sv ====
`default_nettype none

module alu import rv32i_pkg::*; (
  input  alu_ops_t  aluop_i,
  input  rv32i_word a_i,
  input  rv32i_word b_i,
  output rv32i_word f_o
);

  always_comb begin
    case (aluop_i)
      alu_add: f_o = a_i + b_i;
      alu_sll: f_o = a_i << b_i[4:0];
      alu_sra: f_o = rv32i_word'($signed(a_i) >>> b_i[4:0]);
      alu_sub: f_o = a_i - b_i;
      alu_xor: f_o = a_i ^ b_i;
      alu_srl: f_o = a_i >> b_i[4:0];
      alu_or:  f_o = a_i | b_i;
      alu_and: f_o = a_i & b_i;
      default: f_o = a_i + b_i;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/cmp.sv ====
`default_nettype none

module cmp import rv32i_pkg::*; (
  input  branch_funct3_t cmpop_i,
  input  rv32i_word      a_i,
  input  rv32i_word      b_i,
  output logic           br_en_o
);

  always_comb begin
    case (cmpop_i)
      beq:     br_en_o = (a_i == b_i);
      bne:     br_en_o = (a_i != b_i);
      blt:     br_en_o = ($signed(a_i) < $signed(b_i));
      bge:     br_en_o = ($signed(a_i) >= $signed(b_i));
      bltu:    br_en_o = (a_i < b_i);
      bgeu:    br_en_o = (a_i >= b_i);
      default: br_en_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/ex_forward_unit.sv ====
`default_nettype none

module ex_forward_unit import rv32i_pkg::*; (
  input  rv32i_control_word id_ex_i,
  ex_mem_if.consumer        ex_mem,
  input  rv32i_control_word mem_wb_i,
  output fwd_sel_t [1:0]    fwd_alu_o,
  output fwd_sel_t [1:0]    fwd_cmp_o,
  output fwd_sel_t          fwd_rs2_o
);

  fwd_sel_t rs1_sel;
  fwd_sel_t rs2_sel;

  function automatic fwd_sel_t src_sel(input logic [4:0] rs, input rv32i_control_word exm,
                                       input rv32i_control_word mwb);
    fwd_sel_t sel;
    sel = fwd_none;
    if (rs != 5'd0) begin
      if (exm.valid && exm.load_regfile && exm.rd == rs) begin
        sel = fwd_ex_mem;                        // Younger result wins.
      end else if (mwb.valid && mwb.load_regfile && mwb.rd == rs) begin
        sel = fwd_mem_wb;
      end
    end
    return sel;
  endfunction

  assign rs1_sel = src_sel(id_ex_i.rs1, ex_mem.ctrl, mem_wb_i);
  assign rs2_sel = src_sel(id_ex_i.rs2, ex_mem.ctrl, mem_wb_i);

  // ALU inputs may hold PC, zero or an immediate instead of a register.
  assign fwd_alu_o[0] = (id_ex_i.alumux1_sel == a1_rs1) ? rs1_sel : fwd_none;
  assign fwd_alu_o[1] = (id_ex_i.alumux2_sel == a2_rs2) ? rs2_sel : fwd_none;
  assign fwd_cmp_o[0] = rs1_sel;
  assign fwd_cmp_o[1] = rs2_sel;
  assign fwd_rs2_o    = rs2_sel;

endmodule

`default_nettype wire

// ==== hw/instruction_decode.sv ====
`default_nettype none

module instruction_decode import rv32i_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              valid_i,
  input  rv32i_word         pc_i,
  input  rv32i_word         instr_i,
  input  rv32i_word         rs1_data_i,
  input  rv32i_word         rs2_data_i,
  input  logic              stall_i,
  output rv32i_control_word ctrl_word_o,
  output rv32i_word         pc_o,
  output rv32i_word         instruction_o,
  output rv32i_word         alu_in_1_o,
  output rv32i_word         alu_in_2_o,
  output rv32i_word         rs1_out_o,
  output rv32i_word         rs2_o
);

  logic [2:0]        funct3;
  rv32i_word         i_imm;
  rv32i_word         s_imm;
  rv32i_word         b_imm;
  rv32i_word         j_imm;
  rv32i_control_word cw;
  rv32i_word         alu_in_1;
  rv32i_word         alu_in_2;

  assign funct3 = instr_i[14:12];
  assign i_imm  = {{21{instr_i[31]}}, instr_i[30:20]};
  assign s_imm  = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
  assign b_imm  = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign j_imm  = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  always_comb begin
    cw                     = '0;
    cw.opcode              = opcode_t'(instr_i[6:0]);
    cw.funct3              = funct3;
    cw.aluop               = alu_add;
    cw.cmpop               = branch_funct3_t'(funct3);
    cw.rs1                 = instr_i[19:15];
    cw.rd                  = instr_i[11:7];
    cw.u_imm               = {instr_i[31:12], 12'h000};
    cw.imm                 = i_imm;
    cw.alumux1_sel         = a1_rs1;
    cw.alumux2_sel         = a2_imm;
    cw.pcmux_sel           = pc_plus4;
    cw.load_regfilemux_sel = rf_alu;
    cw.load_regfile        = 1'b1;
    cw.valid               = valid_i;
    case (cw.opcode)
      op_lui, op_auipc: begin
        cw.rs1         = 5'd0;
        cw.imm         = cw.u_imm;
        cw.alumux1_sel = (cw.opcode == op_lui) ? a1_zero : a1_pc;
        if (cw.opcode == op_lui) begin
          cw.load_regfilemux_sel = rf_u_imm;
        end
      end
      op_jal, op_jalr: begin
        cw.load_regfilemux_sel = rf_pc4;
        if (cw.opcode == op_jal) begin
          cw.rs1         = 5'd0;
          cw.imm         = j_imm;
          cw.alumux1_sel = a1_pc;
          cw.pcmux_sel   = alu_out;
        end else begin
          cw.pcmux_sel = alu_mod2;
        end
      end
      op_br: begin
        cw.rs2          = instr_i[24:20];
        cw.imm          = b_imm;
        cw.alumux1_sel  = a1_pc;
        cw.pcmux_sel    = alu_out;
        cw.load_regfile = 1'b0;
      end
      op_load: begin
        cw.mem_read            = 1'b1;
        cw.load_regfilemux_sel = rf_load;
      end
      op_store: begin
        cw.rs2          = instr_i[24:20];
        cw.imm          = s_imm;
        cw.mem_write    = 1'b1;
        cw.load_regfile = 1'b0;
      end
      op_imm, op_reg: begin
        cw.aluop = alu_ops_t'(funct3);
        if (cw.opcode == op_reg) begin
          cw.rs2         = instr_i[24:20];
          cw.alumux2_sel = a2_rs2;
        end
        case (funct3)
          3'b000: cw.aluop = (cw.opcode == op_reg && instr_i[30]) ? alu_sub : alu_add;
          3'b010: begin
            cw.cmpop               = blt;
            cw.load_regfilemux_sel = rf_cmp;
          end
          3'b011: begin
            cw.cmpop               = bltu;
            cw.load_regfilemux_sel = rf_cmp;
          end
          3'b101: cw.aluop = instr_i[30] ? alu_sra : alu_srl;
          default: cw.aluop = alu_ops_t'(funct3);
        endcase
      end
      default: begin
        cw.load_regfile = 1'b0;
        cw.valid        = 1'b0;                  // Unsupported opcode.
      end
    endcase
  end

  always_comb begin
    case (cw.alumux1_sel)
      a1_pc:   alu_in_1 = pc_i;
      a1_zero: alu_in_1 = '0;
      default: alu_in_1 = rs1_data_i;
    endcase
    alu_in_2 = (cw.alumux2_sel == a2_rs2) ? rs2_data_i : cw.imm;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_word_o <= '0;
    end else if (!stall_i) begin
      ctrl_word_o <= cw;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      pc_o          <= pc_i;
      instruction_o <= instr_i;
      alu_in_1_o    <= alu_in_1;
      alu_in_2_o    <= alu_in_2;
      rs1_out_o     <= rs1_data_i;
      rs2_o         <= rs2_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== hw/instruction_execute.sv ====
`default_nettype none

module instruction_execute import rv32i_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  rv32i_control_word ctrl_word_i,
  input  rv32i_word         pc_i,
  input  rv32i_word         instruction_i,
  input  rv32i_word         alu_in_1_i,
  input  rv32i_word         alu_in_2_i,
  input  rv32i_word         rs1_out_i,
  input  rv32i_word         rs2_i,
  input  logic              stall_i,
  input  rv32i_control_word mem_wb_ctrl_i,
  input  rv32i_word         mem_wb_data_i,
  ex_mem_if.producer        ex_mem,
  ex_mem_if.consumer        ex_mem_fb,
  output logic              redirect_o,
  output rv32i_word         redirect_pc_o
);

  fwd_sel_t [1:0] fwd_alu;
  fwd_sel_t [1:0] fwd_cmp;
  fwd_sel_t       fwd_rs2;
  rv32i_word      ex_mem_value;
  rv32i_word      alu_a;
  rv32i_word      alu_b;
  rv32i_word      cmp_a;
  rv32i_word      cmp_b;
  rv32i_word      store_data;
  rv32i_word      alu_f;
  logic           br_en;
  logic [3:0]     be_width;
  logic [3:0]     byte_enable;

  function automatic rv32i_word pick(input fwd_sel_t sel, input rv32i_word reg_val,
                                     input rv32i_word exm_val, input rv32i_word mwb_val);
    case (sel)
      fwd_ex_mem: return exm_val;
      fwd_mem_wb: return mwb_val;
      default:    return reg_val;
    endcase
  endfunction

  ex_forward_unit fwd_unit (
    .id_ex_i   (ctrl_word_i),
    .ex_mem    (ex_mem_fb),
    .mem_wb_i  (mem_wb_ctrl_i),
    .fwd_alu_o (fwd_alu),
    .fwd_cmp_o (fwd_cmp),
    .fwd_rs2_o (fwd_rs2)
  );

  // Value the EX/MEM instruction will write back (never a load here).
  always_comb begin
    case (ex_mem_fb.ctrl.load_regfilemux_sel)
      rf_u_imm: ex_mem_value = ex_mem_fb.ctrl.u_imm;
      rf_cmp:   ex_mem_value = {31'd0, ex_mem_fb.br_en};
      rf_pc4:   ex_mem_value = ex_mem_fb.pc + 32'd4;
      default:  ex_mem_value = ex_mem_fb.alu_out;
    endcase
  end

  always_comb begin
    alu_a      = pick(fwd_alu[0], alu_in_1_i, ex_mem_value, mem_wb_data_i);
    alu_b      = pick(fwd_alu[1], alu_in_2_i, ex_mem_value, mem_wb_data_i);
    cmp_a      = pick(fwd_cmp[0], rs1_out_i, ex_mem_value, mem_wb_data_i);
    store_data = pick(fwd_rs2, rs2_i, ex_mem_value, mem_wb_data_i);
    if (ctrl_word_i.opcode == op_imm) begin
      cmp_b = ctrl_word_i.imm;                   // slti and sltiu.
    end else begin
      cmp_b = pick(fwd_cmp[1], rs2_i, ex_mem_value, mem_wb_data_i);
    end
  end

  alu alu_u (
    .aluop_i (ctrl_word_i.aluop),
    .a_i     (alu_a),
    .b_i     (alu_b),
    .f_o     (alu_f)
  );

  cmp cmp_u (
    .cmpop_i (ctrl_word_i.cmpop),
    .a_i     (cmp_a),
    .b_i     (cmp_b),
    .br_en_o (br_en)
  );

  always_comb begin
    redirect_o = 1'b0;
    if (ctrl_word_i.valid && ctrl_word_i.pcmux_sel != pc_plus4) begin
      redirect_o = (ctrl_word_i.opcode != op_br) || br_en;
    end
    redirect_pc_o = (ctrl_word_i.pcmux_sel == alu_mod2) ? {alu_f[31:1], 1'b0} : alu_f;
  end

  always_comb begin
    case (store_funct3_t'({1'b0, ctrl_word_i.funct3[1:0]}))
      sb:      be_width = 4'b0001;
      sh:      be_width = 4'b0011;
      default: be_width = 4'b1111;
    endcase
    byte_enable = 4'b0000;
    if (ctrl_word_i.mem_read || ctrl_word_i.mem_write) begin
      byte_enable = be_width << alu_f[1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_mem.ctrl <= '0;
    end else if (!stall_i) begin
      ex_mem.ctrl <= ctrl_word_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      ex_mem.instruction     <= instruction_i;
      ex_mem.pc              <= pc_i;
      ex_mem.alu_out         <= alu_f;
      ex_mem.br_en           <= br_en;
      ex_mem.rs2_out         <= store_data;
      ex_mem.mem_byte_enable <= byte_enable;
      ex_mem.addr_offset     <= alu_f[1:0];
    end
  end

endmodule

`default_nettype wire

// ==== hw/memory_access.sv ====
`default_nettype none

module memory_access import rv32i_pkg::*; #(
  parameter int DMEM_WORDS = 64
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              stall_i,
  ex_mem_if.consumer        ex_mem,
  output rv32i_control_word mem_wb_ctrl_o,
  output rv32i_word         mem_wb_data_o,
  output logic              wb_valid_o,
  output logic [4:0]        wb_rd_o
);

  localparam int ADDR_W = $clog2(DMEM_WORDS);

  rv32i_word         dmem [DMEM_WORDS];
  logic [ADDR_W-1:0] word_addr;
  rv32i_word         store_word;
  rv32i_word         load_word;
  rv32i_word         load_shifted;
  rv32i_word         load_value;
  rv32i_word         wb_value;
  logic              mem_we;

  assign word_addr  = ex_mem.alu_out[ADDR_W+1:2];
  assign store_word = ex_mem.rs2_out << {ex_mem.addr_offset, 3'b000};
  assign mem_we     = ex_mem.ctrl.valid && ex_mem.ctrl.mem_write && !stall_i && !rst;

  always_ff @(posedge clk) begin
    if (mem_we) begin
      for (int i = 0; i < 4; i++) begin
        if (ex_mem.mem_byte_enable[i]) begin
          dmem[word_addr][8*i +: 8] <= store_word[8*i +: 8];
        end
      end
    end
  end

  assign load_word    = dmem[word_addr];
  assign load_shifted = load_word >> {ex_mem.addr_offset, 3'b000};

  always_comb begin
    case (load_funct3_t'(ex_mem.instruction[14:12]))
      lb:      load_value = {{24{load_shifted[7]}}, load_shifted[7:0]};
      lh:      load_value = {{16{load_shifted[15]}}, load_shifted[15:0]};
      lbu:     load_value = {24'd0, load_shifted[7:0]};
      lhu:     load_value = {16'd0, load_shifted[15:0]};
      default: load_value = load_word;
    endcase
  end

  always_comb begin
    case (ex_mem.ctrl.load_regfilemux_sel)
      rf_cmp:   wb_value = {31'd0, ex_mem.br_en};
      rf_u_imm: wb_value = ex_mem.ctrl.u_imm;
      rf_pc4:   wb_value = ex_mem.pc + 32'd4;
      rf_load:  wb_value = load_value;
      default:  wb_value = ex_mem.alu_out;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wb_ctrl_o <= '0;
    end else if (!stall_i) begin
      mem_wb_ctrl_o <= ex_mem.ctrl;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      mem_wb_data_o <= wb_value;
    end
  end

  assign wb_valid_o = mem_wb_ctrl_o.valid && mem_wb_ctrl_o.load_regfile;
  assign wb_rd_o    = mem_wb_ctrl_o.rd;

endmodule

`default_nettype wire

// ==== hw/rv32i_backend_top.sv ====
`default_nettype none

module rv32i_backend_top import rv32i_pkg::*; #(
  parameter int DMEM_WORDS = 64
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        in_valid_i,
  input  rv32i_word   pc_i,
  input  rv32i_word   instr_i,
  input  rv32i_word   rs1_data_i,
  input  rv32i_word   rs2_data_i,
  input  logic        stall_i,
  output logic        wb_valid_o,
  output logic [4:0]  wb_rd_o,
  output rv32i_word   wb_data_o,
  output logic        redirect_o,
  output rv32i_word   redirect_pc_o
);

  rv32i_control_word id_ex_ctrl;
  rv32i_control_word mem_wb_ctrl;
  rv32i_word         id_ex_pc;
  rv32i_word         id_ex_instr;
  rv32i_word         id_ex_alu_in_1;
  rv32i_word         id_ex_alu_in_2;
  rv32i_word         id_ex_rs1;
  rv32i_word         id_ex_rs2;

  ex_mem_if ex_mem ();

  instruction_decode decode_i (
    .clk           (clk),
    .rst           (rst),
    .valid_i       (in_valid_i),
    .pc_i          (pc_i),
    .instr_i       (instr_i),
    .rs1_data_i    (rs1_data_i),
    .rs2_data_i    (rs2_data_i),
    .stall_i       (stall_i),
    .ctrl_word_o   (id_ex_ctrl),
    .pc_o          (id_ex_pc),
    .instruction_o (id_ex_instr),
    .alu_in_1_o    (id_ex_alu_in_1),
    .alu_in_2_o    (id_ex_alu_in_2),
    .rs1_out_o     (id_ex_rs1),
    .rs2_o         (id_ex_rs2)
  );

  instruction_execute execute_i (
    .clk           (clk),
    .rst           (rst),
    .ctrl_word_i   (id_ex_ctrl),
    .pc_i          (id_ex_pc),
    .instruction_i (id_ex_instr),
    .alu_in_1_i    (id_ex_alu_in_1),
    .alu_in_2_i    (id_ex_alu_in_2),
    .rs1_out_i     (id_ex_rs1),
    .rs2_i         (id_ex_rs2),
    .stall_i       (stall_i),
    .mem_wb_ctrl_i (mem_wb_ctrl),
    .mem_wb_data_i (wb_data_o),
    .ex_mem        (ex_mem.producer),
    .ex_mem_fb     (ex_mem.consumer),
    .redirect_o    (redirect_o),
    .redirect_pc_o (redirect_pc_o)
  );

  memory_access #(
    .DMEM_WORDS (DMEM_WORDS)
  ) mem_i (
    .clk           (clk),
    .rst           (rst),
    .stall_i       (stall_i),
    .ex_mem        (ex_mem.consumer),
    .mem_wb_ctrl_o (mem_wb_ctrl),
    .mem_wb_data_o (wb_data_o),               // Also the MEM/WB forwarding source.
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o)
  );

endmodule

`default_nettype wire

// ==== tests/backend_model.svh ====
`ifndef BACKEND_MODEL_SVH
`define BACKEND_MODEL_SVH

logic [31:0] arch_rf [32];
logic [31:0] mem_model [64];                     // Byte address bits 7:2 pick the word.
logic [4:0]  exp_rd_q [$];
logic [31:0] exp_data_q [$];
logic        exp_taken_q [$];
logic [31:0] exp_target_q [$];

// Executes one instruction in program order and queues what the DUT must show.
task automatic execute_reference(input logic [31:0] ins, input logic [31:0] pc);
  logic [4:0]  rd;
  logic [2:0]  f3;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] i_imm;
  logic [31:0] s_imm;
  logic [31:0] b_imm;
  logic [31:0] j_imm;
  logic [31:0] u_imm;
  logic [31:0] res;
  logic [31:0] addr;
  logic [31:0] w;
  logic [31:0] target;
  logic        writes;
  logic        taken;
  rd     = ins[11:7];
  f3     = ins[14:12];
  a      = arch_rf[ins[19:15]];
  b      = arch_rf[ins[24:20]];
  i_imm  = {{20{ins[31]}}, ins[31:20]};
  s_imm  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
  b_imm  = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
  j_imm  = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
  u_imm  = {ins[31:12], 12'h000};
  res    = 32'd0;
  target = 32'd0;
  writes = 1'b1;
  taken  = 1'b0;
  case (ins[6:0])
    7'h37: res = u_imm;
    7'h17: res = pc + u_imm;
    7'h6f: begin
      res    = pc + 32'd4;
      taken  = 1'b1;
      target = pc + j_imm;
    end
    7'h67: begin
      res    = pc + 32'd4;
      taken  = 1'b1;
      target = (a + i_imm) & ~32'd1;
    end
    7'h63: begin
      writes = 1'b0;
      target = pc + b_imm;
      case (f3)
        3'd0:    taken = (a == b);
        3'd1:    taken = (a != b);
        3'd4:    taken = ($signed(a) < $signed(b));
        3'd5:    taken = ($signed(a) >= $signed(b));
        3'd6:    taken = (a < b);
        default: taken = (a >= b);
      endcase
    end
    7'h03: begin
      addr = a + i_imm;
      w    = mem_model[addr[7:2]] >> (8 * addr[1:0]);
      case (f3)
        3'd0:    res = {{24{w[7]}}, w[7:0]};
        3'd1:    res = {{16{w[15]}}, w[15:0]};
        3'd4:    res = {24'd0, w[7:0]};
        3'd5:    res = {16'd0, w[15:0]};
        default: res = w;
      endcase
    end
    7'h23: begin
      writes = 1'b0;
      addr   = a + s_imm;
      w      = mem_model[addr[7:2]];
      case (f3)
        3'd0:    w[8 * addr[1:0] +: 8] = b[7:0];
        3'd1:    w[8 * addr[1:0] +: 16] = b[15:0];
        default: w = b;
      endcase
      mem_model[addr[7:2]] = w;
    end
    default: begin                               // Register and immediate ALU forms.
      if (ins[6:0] == 7'h13) begin
        b = i_imm;
      end
      case (f3)
        3'd0:    res = (ins[6:0] == 7'h33 && ins[30]) ? a - b : a + b;
        3'd1:    res = a << b[4:0];
        3'd2:    res = {31'd0, $signed(a) < $signed(b)};
        3'd3:    res = {31'd0, a < b};
        3'd4:    res = a ^ b;
        3'd5: begin
          if (ins[30]) begin
            res = $signed(a) >>> b[4:0];
          end else begin
            res = a >> b[4:0];
          end
        end
        3'd6:    res = a | b;
        default: res = a & b;
      endcase
    end
  endcase
  if (writes) begin
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(res);
    if (rd != 5'd0) begin
      arch_rf[rd] = res;
    end
  end
  exp_taken_q.push_back(taken);
  exp_target_q.push_back(target);
endtask

`endif

// ==== tests/tb_backend.sv ====
`default_nettype none

module tb_backend;

  localparam logic [31:0] PC_BASE  = 32'h0000_0100;
  localparam logic [31:0] NOP      = 32'h0000_0013;
  localparam int          N_RANDOM = 300;

  logic        clk;
  logic        rst;
  logic        in_valid_i;
  logic [31:0] pc_i;
  logic [31:0] instr_i;
  logic [31:0] rs1_data_i;
  logic [31:0] rs2_data_i;
  logic        stall_i;
  logic        wb_valid_o;
  logic [4:0]  wb_rd_o;
  logic [31:0] wb_data_o;
  logic        redirect_o;
  logic [31:0] redirect_pc_o;

  logic [31:0] prog_q [$];
  int unsigned stall_q [$];
  int unsigned total_stall;
  int unsigned stall_left;
  int unsigned timeout_limit;
  int unsigned cycle_cnt;
  int unsigned commit_cnt;
  int unsigned redirect_cnt;
  logic [31:0] commit_rf [32];                   // Register file as the fetch side sees it.

  `include "backend_model.svh"

  rv32i_backend_top #(
    .DMEM_WORDS (64)
  ) dut_i (
    .clk           (clk),
    .rst           (rst),
    .in_valid_i    (in_valid_i),
    .pc_i          (pc_i),
    .instr_i       (instr_i),
    .rs1_data_i    (rs1_data_i),
    .rs2_data_i    (rs2_data_i),
    .stall_i       (stall_i),
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o),
    .redirect_o    (redirect_o),
    .redirect_pc_o (redirect_pc_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > timeout_limit) begin
      $display("Timeout: pipeline did not finish within %0d cycles", timeout_limit);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_format(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_format(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] u_format(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_format(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // Byte address inside the 64-word memory, aligned for the access width.
  function automatic logic [11:0] aligned_addr(input logic [1:0] width);
    logic [7:0] a;
    a = {6'($urandom_range(0, 63)), 2'b00};
    if (width == 2'd0) begin
      a[1:0] = 2'($urandom);
    end else if (width == 2'd1) begin
      a[1] = 1'($urandom);
    end
    return {4'd0, a};
  endfunction

  task automatic add_instr(input logic [31:0] ins);
    int unsigned stall;
    stall = ($urandom_range(0, 5) == 0) ? $urandom_range(1, 3) : 0;
    prog_q.push_back(ins);
    stall_q.push_back(stall);
    total_stall += stall;
  endtask

  task automatic random_instr(output logic [31:0] ins);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic        alt;
    rd  = 5'($urandom_range(0, 7));
    rs1 = 5'($urandom_range(0, 7));
    rs2 = 5'($urandom_range(0, 7));
    f3  = 3'($urandom);
    imm = 12'($urandom);
    alt = 1'($urandom);
    case ($urandom_range(0, 9))
      0: ins = r_format({1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'd0}, rs2, rs1, f3, rd);
      1, 2: begin
        if (f3 == 3'd1) begin
          imm = {7'd0, imm[4:0]};
        end else if (f3 == 3'd5) begin
          imm = {1'b0, alt, 5'd0, imm[4:0]};       // srli or srai.
        end
        ins = i_format(imm, rs1, f3, rd, 7'h13);
      end
      3: ins = u_format(20'($urandom), rd, 7'h37);
      4: ins = u_format(20'($urandom), rd, 7'h17);
      5: begin
        while (f3 == 3'd2 || f3 == 3'd3) begin
          f3 = 3'($urandom);
        end
        ins = b_format({12'($urandom), 1'b0}, rs2, rs1, f3);
      end
      6: ins = j_format({20'($urandom), 1'b0}, rd);
      7: ins = i_format(imm, rs1, 3'd0, rd, 7'h67);
      8: begin
        while (f3 == 3'd3 || f3 > 3'd5) begin
          f3 = 3'($urandom);
        end
        ins = i_format(aligned_addr(f3[1:0]), 5'd0, f3, rd, 7'h03);
      end
      default: begin
        f3  = 3'($urandom_range(0, 2));
        ins = s_format(aligned_addr(f3[1:0]), rs2, 5'd0, f3);
      end
    endcase
  endtask

  task automatic build_program();
    logic [31:0] ins;
    for (int r = 1; r < 8; r++) begin
      add_instr(u_format(20'($urandom), 5'(r), 7'h37));
      add_instr(i_format(12'($urandom), 5'(r), 3'd0, 5'(r), 7'h13));
    end
    for (int w = 0; w < 64; w++) begin
      add_instr(s_format(12'(4 * w), 5'($urandom_range(1, 7)), 5'd0, 3'd2));
    end
    for (int n = 0; n < N_RANDOM; n++) begin
      random_instr(ins);
      add_instr(ins);
      if (ins[6:0] == 7'h03) begin
        add_instr(NOP);                          // Keeps loads away from their users.
      end
    end
  endtask

  task automatic present_instr(input int unsigned k);
    logic [31:0] ins;
    logic [31:0] pc;
    ins        = prog_q[k];
    pc         = PC_BASE + 32'(4 * k);
    in_valid_i = 1'b1;
    pc_i       = pc;
    instr_i    = ins;
    // A result retiring at the coming edge is already in commit_rf.
    rs1_data_i = commit_rf[ins[19:15]];
    rs2_data_i = commit_rf[ins[24:20]];
    execute_reference(ins, pc);
    stall_left = stall_q[k];
  endtask

  task automatic retire_result();
    logic [4:0]  rd;
    logic [31:0] data;
    if (exp_rd_q.size() == 0) begin
      $display("Writeback to x%0d seen with no instruction pending", wb_rd_o);
      $display("Simulation failed");
      $fatal(1, "unexpected writeback");
    end else begin
      rd   = exp_rd_q.pop_front();
      data = exp_data_q.pop_front();
      check_value($sformatf("commit %0d rd", commit_cnt), {27'd0, rd}, {27'd0, wb_rd_o});
      check_value($sformatf("commit %0d data", commit_cnt), data, wb_data_o);
      if (rd != 5'd0) begin
        commit_rf[rd] = data;
      end
      commit_cnt++;
    end
  endtask

  task automatic check_redirect();
    logic        taken;
    logic [31:0] target;
    taken  = exp_taken_q.pop_front();
    target = exp_target_q.pop_front();
    check_value($sformatf("redirect %0d taken", redirect_cnt), {31'd0, taken},
                {31'd0, redirect_o});
    if (taken) begin
      check_value($sformatf("redirect %0d target", redirect_cnt), target, redirect_pc_o);
    end
    redirect_cnt++;
  endtask

  initial begin
    int unsigned idx;
    logic        issued;
    void'($urandom(17));
    rst           = 1'b1;
    in_valid_i    = 1'b0;
    pc_i          = 32'd0;
    instr_i       = NOP;
    rs1_data_i    = 32'd0;
    rs2_data_i    = 32'd0;
    stall_i       = 1'b0;
    total_stall   = 0;
    stall_left    = 0;
    cycle_cnt     = 0;
    commit_cnt    = 0;
    redirect_cnt  = 0;
    for (int r = 0; r < 32; r++) begin
      arch_rf[r]   = 32'd0;
      commit_rf[r] = 32'd0;
    end
    build_program();
    timeout_limit = 4 * (prog_q.size() + total_stall) + 20;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_value("idle wb_valid_o", 32'd0, {31'd0, wb_valid_o});
    check_value("idle redirect_o", 32'd0, {31'd0, redirect_o});
    idx    = 0;
    issued = 1'b0;
    while (idx < prog_q.size() || exp_rd_q.size() != 0 || exp_taken_q.size() != 0) begin
      if (issued) begin
        check_redirect();                        // ID/EX holds the instruction sampled last.
      end
      if (stall_left != 0) begin
        stall_i = 1'b1;
        stall_left--;
        issued  = 1'b0;
      end else begin
        stall_i = 1'b0;
        if (wb_valid_o) begin
          retire_result();
        end
        if (idx < prog_q.size()) begin
          present_instr(idx);
          idx++;
          issued = 1'b1;
        end else begin
          in_valid_i = 1'b0;
          issued     = 1'b0;
        end
      end
      @(negedge clk);
    end
    repeat (3) begin
      check_value("drained wb_valid_o", 32'd0, {31'd0, wb_valid_o});
      @(negedge clk);
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+tests
hw/rv32i_pkg.sv
hw/ex_mem_if.sv
hw/alu.sv
hw/cmp.sv
hw/ex_forward_unit.sv
hw/instruction_decode.sv
hw/instruction_execute.sv
hw/memory_access.sv
hw/rv32i_backend_top.sv
tests/tb_backend.sv
